//--- hdl/mul_pkg.sv
package mul_pkg;

	// datapath sizes
	localparam int XLEN = 32;
	localparam int MUL_OPND_W = XLEN + 1; // extra bit carries the sign extension
	localparam int RD_ID_W = 5;
	localparam int MUL_FIFO_DEPTH = 2;

	// dsp slice and accumulator
	localparam int ACCUM_W = 48;
	localparam int DSP_W = 18;
	localparam int DSP_PROD_W = 2 * DSP_W;
	localparam int LOW_PART_W = 17; // low slice of each operand, zero extended

	// same encoding as funct3[1:0]
	typedef enum logic [1:0]
	{
		OP_MUL    = 2'b00,
		OP_MULH   = 2'b01,
		OP_MULHSU = 2'b10,
		OP_MULHU  = 2'b11
	} mul_op_e;

	typedef struct packed
	{
		mul_op_e              op;
		logic [XLEN-1:0]      rs1;
		logic [XLEN-1:0]      rs2;
		logic [RD_ID_W-1:0]   rd_id;
	} mul_op_t;

	typedef struct packed
	{
		logic                  res_sel; // 1 picks the upper word
		logic [MUL_OPND_W-1:0] op_a;
		logic [MUL_OPND_W-1:0] op_b;
		logic [RD_ID_W-1:0]    rd_id;
	} mul_req_t;

	typedef struct packed
	{
		logic [XLEN-1:0]    data;
		logic [RD_ID_W-1:0] rd_id;
	} mul_res_t;

endpackage

//--- hdl/mul_req_fifo.sv
`timescale 1ns/100ps

module mul_req_fifo import mul_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,

	input  logic     wr_en,
	input  mul_req_t din,
	output logic     not_full,

	input  logic     rd_en,
	output mul_req_t dout,
	output logic     not_empty
);

	localparam int PTR_W = $clog2(MUL_FIFO_DEPTH);
	localparam int CNT_W = $clog2(MUL_FIFO_DEPTH + 1);

	mul_req_t mem [MUL_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	assign not_full = (count != CNT_W'(MUL_FIFO_DEPTH));
	assign not_empty = (count != '0);

	assign do_wr = wr_en & not_full; // full buffer drops the write
	assign do_rd = rd_en & not_empty;

	// head entry shows without a read
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// occupancy
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			count <= '0;
		else if (do_wr && !do_rd)
			count <= count + 1'b1;
		else if (do_rd && !do_wr)
			count <= count - 1'b1;
	end

endmodule

//--- hdl/mul_18x18.sv
`timescale 1ns/100ps

// dsp style signed multiplier
// product register followed by an output register
module mul_18x18 import mul_pkg::*;
(
	input  logic                         clk,

	input  logic signed [DSP_W-1:0]      a,
	input  logic signed [DSP_W-1:0]      b,
	input  logic                         in_en,  // loads the product register
	input  logic                         out_en, // loads the output register

	output logic signed [DSP_PROD_W-1:0] p
);

	logic signed [DSP_PROD_W-1:0] prod_q;
	logic signed [DSP_PROD_W-1:0] p_q;

	// multiply stage
	always_ff @(posedge clk)
	begin
		if (in_en)
			prod_q <= a * b;
	end

	// output stage
	always_ff @(posedge clk)
	begin
		if (out_en)
			p_q <= prod_q;
	end

	assign p = p_q;

endmodule

//--- hdl/multiplier.sv
`timescale 1ns/100ps

// 33x33 signed multiplier on one 18x18 dsp
// buffer write 1 cycle, compute 6 cycles, output register 1 cycle
module multiplier import mul_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,

	input  mul_req_t req,
	input  logic     req_valid,
	output logic     req_ready,

	output mul_res_t res,
	output logic     res_valid,
	input  logic     res_ready
);

	localparam int HIGH_PART_W = MUL_OPND_W - LOW_PART_W; // 16 bit signed upper slice
	localparam int FULL_W = ACCUM_W + LOW_PART_W;          // 65 bit product

	// request buffer
	mul_req_t head;
	logic     buf_not_full;
	logic     buf_not_empty;
	logic     buf_rd_en;

	// controller and dsp
	logic [6:0]                   state; // one hot
	logic                         step;
	logic                         dsp_in_en;
	logic                         dsp_in_en_d;
	logic signed [DSP_W-1:0]      dsp_a;
	logic signed [DSP_W-1:0]      dsp_b;
	logic signed [DSP_PROD_W-1:0] dsp_p;

	// accumulation
	logic [ACCUM_W-1:0]    accum;
	logic [ACCUM_W-1:0]    accum_in;
	logic [LOW_PART_W-1:0] low_part;
	logic [FULL_W-1:0]     full_prod;

	// output stage
	mul_res_t res_d;
	mul_res_t res_q;
	logic     res_valid_q;
	logic     out_ready;

	// low slice zero extended or high slice sign extended to the dsp width
	function automatic logic [DSP_W-1:0] dsp_slice(input logic [MUL_OPND_W-1:0] v,
		input logic high);
		if (high)
			return {{(DSP_W - HIGH_PART_W){v[MUL_OPND_W-1]}}, v[MUL_OPND_W-1:LOW_PART_W]};
		else
			return {{(DSP_W - LOW_PART_W){1'b0}}, v[LOW_PART_W-1:0]};
	endfunction

	assign req_ready = buf_not_full;

	mul_req_fifo req_buf
	(
		.clk       (clk),
		.resetn    (resetn),
		.wr_en     (req_valid & req_ready),
		.din       (req),
		.not_full  (buf_not_full),
		.rd_en     (buf_rd_en),
		.dout      (head),
		.not_empty (buf_not_empty)
	);

	// issue order ll, hl, lh, hh in states 0 to 3
	assign dsp_a = dsp_slice(head.op_a, state[1] | state[3]);
	assign dsp_b = dsp_slice(head.op_b, state[2] | state[3]);
	assign dsp_in_en = (state[0] & buf_not_empty) | state[1] | state[2] | state[3];

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			dsp_in_en_d <= 1'b0;
		else
			dsp_in_en_d <= dsp_in_en;
	end

	mul_18x18 dsp0
	(
		.clk    (clk),
		.a      (dsp_a),
		.b      (dsp_b),
		.in_en  (dsp_in_en),
		.out_en (dsp_in_en_d), // product lands two edges after issue
		.p      (dsp_p)
	);

	// wait for a request in state 0 and for the output stage in state 6
	assign step = (state[0] & buf_not_empty) |
		(~state[0] & ~state[6]) |
		(state[6] & out_ready);

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			state <= 7'b0000001;
		else if (step)
			state <= {state[5:0], state[6]};
	end

	// pop once the result has moved into the output stage
	assign buf_rd_en = state[6] & out_ready;

	always_comb
	begin
		accum_in = '0;
		if (state[2])
			accum_in = {{(ACCUM_W - DSP_PROD_W + LOW_PART_W){1'b0}},
				dsp_p[DSP_PROD_W-1:LOW_PART_W]}; // ll >> 17
		else if (state[3] || state[4])
			accum_in = {{(ACCUM_W - DSP_PROD_W){dsp_p[DSP_PROD_W-1]}}, dsp_p}; // cross terms
		else if (state[5])
			accum_in = {dsp_p[ACCUM_W-LOW_PART_W-1:0], {LOW_PART_W{1'b0}}}; // hh << 17
	end

	always_ff @(posedge clk)
	begin
		if (state[1])
			accum <= '0;
		else if (|state[5:2])
			accum <= accum + accum_in;
	end

	// low 17 bits of the product come straight from ll
	always_ff @(posedge clk)
	begin
		if (state[2])
			low_part <= dsp_p[LOW_PART_W-1:0];
	end

	assign full_prod = {accum, low_part};

	always_comb
	begin
		res_d.rd_id = head.rd_id;
		if (head.res_sel)
			res_d.data = full_prod[2*XLEN-1:XLEN];
		else
			res_d.data = full_prod[XLEN-1:0];
	end

	assign out_ready = ~res_valid_q | res_ready; // empty or draining

	always_ff @(posedge clk)
	begin
		if (state[6] && out_ready)
			res_q <= res_d;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			res_valid_q <= 1'b0;
		else if (out_ready)
			res_valid_q <= state[6];
	end

	assign res = res_q;
	assign res_valid = res_valid_q;

endmodule

//--- hdl/mul_unit.sv
`timescale 1ns/100ps

// rv32m multiply unit
// turns MUL/MULH/MULHSU/MULHU into a 33x33 signed request
module mul_unit import mul_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,

	input  mul_op_t  op,
	input  logic     op_valid,
	output logic     op_ready,

	output mul_res_t res,
	output logic     res_valid,
	input  logic     res_ready
);

	mul_req_t req;
	logic     req_ready;
	logic     sign_a; // rs1 treated as signed
	logic     sign_b; // rs2 treated as signed
	logic     res_sel;

	always_comb
	begin
		sign_a = 1'b0;
		sign_b = 1'b0;
		res_sel = 1'b1;
		case (op.op)
			OP_MUL:
			begin
				res_sel = 1'b0; // low word is the same for any signedness
			end
			OP_MULH:
			begin
				sign_a = 1'b1;
				sign_b = 1'b1;
			end
			OP_MULHSU:
			begin
				sign_a = 1'b1;
			end
			default: ; // MULHU
		endcase
	end

	assign req.res_sel = res_sel;
	assign req.op_a = {sign_a & op.rs1[XLEN-1], op.rs1};
	assign req.op_b = {sign_b & op.rs2[XLEN-1], op.rs2};
	assign req.rd_id = op.rd_id;

	assign op_ready = req_ready;

	multiplier mul0
	(
		.clk       (clk),
		.resetn    (resetn),
		.req       (req),
		.req_valid (op_valid),
		.req_ready (req_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

endmodule

//--- verification/mul_unit_tb.sv
`timescale 1ns/100ps

module mul_unit_tb import mul_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int N_OPS = 400;
	localparam int LATENCY = 7;   // accepting edge to res_valid
	localparam int OP_CYCLES = 7; // one result per 7 cycles
	localparam int DRAIN_CYCLES = 20 * OP_CYCLES;
	localparam int WATCHDOG_CYCLES = N_OPS * OP_CYCLES * 4 + 1000;

	logic     clk;
	logic     resetn;
	mul_op_t  op;
	logic     op_valid;
	logic     op_ready;
	mul_res_t res;
	logic     res_valid;
	logic     res_ready;

	mul_res_t exp_q[$]; // expected results in request order
	mul_res_t held_res;
	logic     stalled;
	int       value_errors;
	int       ctrl_errors;
	int       ready_mode; // 0 high, 1 low, 2 random

	mul_unit dut0
	(
		.clk       (clk),
		.resetn    (resetn),
		.op        (op),
		.op_valid  (op_valid),
		.op_ready  (op_ready),
		.res       (res),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// 64 bit reference of the rv32m multiply
	function automatic mul_res_t expected_result(input mul_op_t o);
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] prod;
		mul_res_t r;
		a = {32'b0, o.rs1};
		b = {32'b0, o.rs2};
		if (o.op == OP_MULH || o.op == OP_MULHSU)
			a = {{32{o.rs1[31]}}, o.rs1};
		if (o.op == OP_MULH)
			b = {{32{o.rs2[31]}}, o.rs2};
		prod = a * b;
		r.rd_id = o.rd_id;
		r.data = (o.op == OP_MUL) ? prod[31:0] : prod[63:32];
		return r;
	endfunction

	// half of the operands are corner values
	function automatic logic [XLEN-1:0] random_operand();
		logic [XLEN-1:0] v;
		case ($urandom_range(9))
			0: v = '0;
			1: v = 32'h0000_0001;
			2: v = '1;
			3: v = 32'h8000_0000;
			4: v = 32'h7fff_ffff;
			default: v = $urandom;
		endcase
		return v;
	endfunction

	function automatic mul_op_t random_op();
		mul_op_t o;
		o.op = mul_op_e'($urandom_range(3));
		o.rs1 = random_operand();
		o.rs2 = random_operand();
		o.rd_id = RD_ID_W'($urandom);
		return o;
	endfunction

	task automatic check_res(input mul_res_t got, input mul_res_t exp, input string what);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR %0t: %s data %h rd_id %0d, expected data %h rd_id %0d",
				$time, what, got.data, got.rd_id, exp.data, exp.rd_id);
		end
	endtask

	task automatic check_flag(input bit got, input bit exp, input string what);
		if (got !== exp)
		begin
			ctrl_errors++;
			$display("ERROR %0t: %s is %0b, expected %0b", $time, what, got, exp);
		end
	endtask

	// starts right after a rising edge, returns on the accepting edge
	task automatic send_op(input mul_op_t o);
		bit done;
		done = 1'b0;
		op <= o;
		op_valid <= 1'b1;
		while (!done)
		begin
			@(negedge clk);
			if (op_ready)
			begin
				exp_q.push_back(expected_result(o));
				done = 1'b1;
			end
			@(posedge clk);
		end
	endtask

	// bounded wait for outstanding results
	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_CYCLES)
		begin
			@(negedge clk);
			n++;
		end
	endtask

	always @(posedge clk)
	begin
		if (ready_mode == 0)
			res_ready <= 1'b1;
		else if (ready_mode == 1)
			res_ready <= 1'b0;
		else
			res_ready <= ($urandom_range(99) >= 30); // low about 30% of cycles
	end

	// scoreboard, sampled mid cycle
	always @(negedge clk)
	begin
		if (resetn)
		begin
			if (stalled)
			begin
				check_flag(res_valid, 1'b1, "res_valid held while stalled");
				check_res(res, held_res, "stalled result changed,");
			end
			if (res_valid && res_ready)
			begin
				if (exp_q.size() == 0)
				begin
					ctrl_errors++;
					$display("unexpected result for rd_id %0d at %0t with nothing outstanding",
						res.rd_id, $time);
				end
				else
					check_res(res, exp_q.pop_front(), "result");
			end
			stalled = res_valid && !res_ready;
			held_res = res;
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("run timed out after %0d cycles with %0d results still outstanding",
			WATCHDOG_CYCLES, exp_q.size());
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		mul_op_t o;
		int gap;
		void'($urandom(32'ha4e3));
		value_errors = 0;
		ctrl_errors = 0;
		ready_mode = 0;
		stalled = 1'b0;
		held_res = '0;
		resetn = 1'b0;
		op = '0;
		op_valid = 1'b0;
		res_ready = 1'b1;
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check_flag(res_valid, 1'b0, "res_valid after reset");
		check_flag(op_ready, 1'b1, "op_ready after reset");

		// lone operation into an idle unit
		@(posedge clk);
		send_op(random_op());
		op_valid <= 1'b0;
		for (int k = 1; k <= LATENCY; k++)
		begin
			@(posedge clk);
			@(negedge clk);
			check_flag(res_valid, k == LATENCY, "res_valid during latency");
		end

		// back pressure: two buffered and one in the output register
		wait_drain();
		ready_mode = 1;
		@(posedge clk);
		for (int i = 0; i < 3; i++)
			send_op(random_op());
		o = random_op();
		op <= o; // fourth one is offered and must wait
		op_valid <= 1'b1;
		repeat (3 * OP_CYCLES) @(posedge clk);
		@(negedge clk);
		check_flag(op_ready, 1'b0, "op_ready with three accepted");
		check_flag(res_valid, 1'b1, "res_valid under back pressure");
		check_flag(dut0.mul0.state[6], 1'b1, "controller in state 6");
		if (exp_q.size() != 0)
			check_res(res, exp_q[0], "oldest result held under back pressure");
		ready_mode = 2;
		@(posedge clk);
		send_op(o);

		// random traffic
		for (int i = 5; i < N_OPS; i++)
		begin
			gap = $urandom_range(3);
			if (gap != 0)
			begin
				op_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			send_op(random_op());
		end
		op_valid <= 1'b0;

		wait_drain();
		ready_mode = 0;
		repeat (2 * OP_CYCLES) @(negedge clk);
		check_flag(res_valid, 1'b0, "res_valid after the last result");
		if (exp_q.size() != 0)
		begin
			ctrl_errors++;
			$display("%0d results never came out", exp_q.size());
		end

		$display("value errors: %0d, control errors: %0d", value_errors, ctrl_errors);
		if (value_errors == 0 && ctrl_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- src.f
hdl/mul_pkg.sv
hdl/mul_req_fifo.sv
hdl/mul_18x18.sv
hdl/multiplier.sv
hdl/mul_unit.sv
verification/mul_unit_tb.sv
